//--- logic/vu_consts.svh
// Lane count, element and register sizes, FIFO depth and RVV field encodings
`ifndef VU_CONSTS_SVH
`define VU_CONSTS_SVH

// Machine shape
`define VU_NR_LANES    2
`define VU_ELEM_W      32
`define VU_VLMAX       8
`define VU_NR_VREGS    32
`define VU_FIFO_DEPTH  4

// Major opcode and funct3 groups
`define VU_OPC_OPV     7'b1010111
`define VU_F3_OPIVV    3'b000
`define VU_F3_OPIVI    3'b011
`define VU_F3_OPMVV    3'b010
`define VU_F3_OPCFG    3'b111

// funct6 codes of the kept operations
`define VU_F6_ADD      6'b000000
`define VU_F6_SUB      6'b000010
`define VU_F6_AND      6'b001001
`define VU_F6_OR       6'b001010
`define VU_F6_XOR      6'b001011
`define VU_F6_MV       6'b010111
`define VU_F6_VID      6'b010100
`define VU_VID_VS1     5'b10001

`endif

//--- logic/vu_pkg.sv
// Element and index typedefs, operation and FSM enums, decoded instruction and lane request structs
`include "vu_consts.svh"

package vu_pkg;

  // Widths with a meaning of their own
  typedef logic [`VU_ELEM_W-1:0]                          elem_t;
  typedef logic [$clog2(`VU_NR_VREGS)-1:0]                vreg_t;
  // Holds 0 up to VLMAX inclusive
  typedef logic [$clog2(`VU_VLMAX):0]                     vl_t;
  typedef logic [$clog2(`VU_VLMAX)-1:0]                   elem_idx_t;
  typedef logic [$clog2(`VU_VLMAX / `VU_NR_LANES)-1:0]    lane_elem_t;
  typedef logic [31:0]                                    insn_t;
  typedef logic [4:0]                                     imm_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_MVI,
    OP_VID,
    OP_SETVL
  } vu_op_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT
  } seq_state_e;

  typedef enum logic {
    LANE_IDLE,
    LANE_RUN
  } lane_state_e;

  // Pre-decoded word as stored in the FIFO, imm is the uimm for OP_SETVL
  typedef struct packed {
    vu_op_e op;
    vreg_t  vd;
    vreg_t  vs1;
    vreg_t  vs2;
    imm_t   imm;
  } vu_insn_t;

  // Broadcast to every lane
  typedef struct packed {
    vu_op_e op;
    vreg_t  vd;
    vreg_t  vs1;
    vreg_t  vs2;
    imm_t   imm;
    vl_t    vl;
  } lane_req_t;

endpackage

//--- logic/vu_issue_decoder.sv
// Combinational pre-decoder that checks an issued word and builds the decoded instruction
`timescale 1ns/1ps
`include "vu_consts.svh"

module vu_issue_decoder (
  input  logic             issue_valid_i,
  input  vu_pkg::insn_t    issue_instr_i,
  input  logic             fifo_full_i,
  output logic             issue_accept_o,
  output logic             push_o,
  output vu_pkg::vu_insn_t insn_o
);

  import vu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       vm;
  vreg_t      vs1_f;
  vreg_t      vs2_f;
  logic       legal;
  vu_op_e     op;

  // RVV field positions
  assign opcode = issue_instr_i[6:0];
  assign funct3 = issue_instr_i[14:12];
  assign funct6 = issue_instr_i[31:26];
  assign vm     = issue_instr_i[25];
  assign vs1_f  = issue_instr_i[19:15];
  assign vs2_f  = issue_instr_i[24:20];

  always_comb begin
    legal = 1'b0;
    op    = OP_ADD;
    if (opcode == `VU_OPC_OPV) begin
      case (funct3)
        `VU_F3_OPIVV: begin
          legal = vm;
          case (funct6)
            `VU_F6_ADD: op = OP_ADD;
            `VU_F6_SUB: op = OP_SUB;
            `VU_F6_AND: op = OP_AND;
            `VU_F6_OR:  op = OP_OR;
            `VU_F6_XOR: op = OP_XOR;
            default:    legal = 1'b0;
          endcase
        end
        `VU_F3_OPIVI: begin
          legal = vm;
          case (funct6)
            `VU_F6_ADD: op = OP_ADDI;
            // vmv.v.i needs vs2 cleared
            `VU_F6_MV: begin
              op    = OP_MVI;
              legal = vm && (vs2_f == '0);
            end
            default:    legal = 1'b0;
          endcase
        end
        `VU_F3_OPMVV: begin
          op    = OP_VID;
          legal = vm && (funct6 == `VU_F6_VID) && (vs1_f == `VU_VID_VS1) && (vs2_f == '0);
        end
        // Only the vsetivli flavour of the config group
        `VU_F3_OPCFG: begin
          op    = OP_SETVL;
          legal = (issue_instr_i[31:30] == 2'b11);
        end
        default: legal = 1'b0;
      endcase
    end
  end

  assign issue_accept_o = legal && !fifo_full_i;
  assign push_o         = issue_valid_i && issue_accept_o;

  assign insn_o = '{
    op:  op,
    vd:  issue_instr_i[11:7],
    vs1: vs1_f,
    vs2: vs2_f,
    imm: issue_instr_i[19:15]
  };

endmodule

//--- logic/vu_insn_fifo.sv
// First-word-fall-through FIFO with parameterized depth and stored type
`timescale 1ns/1ps

module vu_insn_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  dtype mem_q [DEPTH];
  ptr_t rd_ptr_q;
  ptr_t wr_ptr_q;
  cnt_t count_q;
  logic do_push;
  logic do_pop;

  assign full_o  = (count_q == cnt_t'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  // Head entry is always on the output
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_t'(do_push) - cnt_t'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- logic/vu_sequencer.sv
// Sequencer holding vl, running vsetivli and broadcasting lane requests until all lanes finish
`timescale 1ns/1ps
`include "vu_consts.svh"

module vu_sequencer (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  vu_pkg::vu_insn_t        insn_i,
  input  logic                    empty_i,
  output logic                    pop_o,
  output vu_pkg::lane_req_t       lane_req_o,
  output logic                    lane_req_valid_o,
  input  logic [`VU_NR_LANES-1:0] lane_done_i,
  output logic                    idle_o
);

  import vu_pkg::*;

  seq_state_e              state_q;
  vl_t                     vl_q;
  vl_t                     setvl_val;
  logic [`VU_NR_LANES-1:0] done_q;
  logic [`VU_NR_LANES-1:0] done_seen;
  lane_req_t               req_q;
  logic                    is_setvl;

  ////////////////////////////////////////////////////////////
  // Pop and vl update
  ////////////////////////////////////////////////////////////

  assign pop_o    = (state_q == SEQ_IDLE) && !empty_i;
  assign is_setvl = (insn_i.op == OP_SETVL);

  // Requested uimm, clamped to VLMAX
  always_comb begin
    if (insn_i.imm > imm_t'(`VU_VLMAX)) begin
      setvl_val = vl_t'(`VU_VLMAX);
    end else begin
      setvl_val = vl_t'(insn_i.imm);
    end
  end

  // Lanes done so far, this cycle included
  assign done_seen = done_q | lane_done_i;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SEQ_IDLE;
      vl_q    <= vl_t'(`VU_VLMAX);
      done_q  <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (pop_o) begin
            if (is_setvl) begin
              vl_q <= setvl_val;
            end else begin
              state_q <= SEQ_ISSUE;
              done_q  <= '0;
            end
          end
        end
        // One cycle of request broadcast
        SEQ_ISSUE: begin
          state_q <= SEQ_WAIT;
          done_q  <= done_seen;
        end
        SEQ_WAIT: begin
          done_q <= done_seen;
          if (&done_seen) begin
            state_q <= SEQ_IDLE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Request payload, taken with the current vl
  always_ff @(posedge clk_i) begin
    if (pop_o && !is_setvl) begin
      req_q <= '{
        op:  insn_i.op,
        vd:  insn_i.vd,
        vs1: insn_i.vs1,
        vs2: insn_i.vs2,
        imm: insn_i.imm,
        vl:  vl_q
      };
    end
  end

  assign lane_req_o       = req_q;
  assign lane_req_valid_o = (state_q == SEQ_ISSUE);
  assign idle_o           = (state_q == SEQ_IDLE);

endmodule

//--- logic/vu_lane.sv
// Vector lane with its register file slice, element loop and registered debug read
`timescale 1ns/1ps
`include "vu_consts.svh"

module vu_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  vu_pkg::lane_req_t  lane_req_i,
  input  logic               lane_req_valid_i,
  output logic               lane_done_o,
  input  vu_pkg::vreg_t      rd_vreg_i,
  input  vu_pkg::lane_elem_t rd_lelem_i,
  output vu_pkg::elem_t      rd_data_o
);

  import vu_pkg::*;

  localparam int unsigned LaneElems = `VU_VLMAX / `VU_NR_LANES;

  // Counts 0 up to LaneElems inclusive
  typedef logic [$clog2(LaneElems):0] cnt_t;

  elem_t       vrf_q [`VU_NR_VREGS][LaneElems];
  lane_req_t   req_q;
  lane_state_e state_q;
  cnt_t        elem_q;
  cnt_t        cnt_q;
  cnt_t        req_cnt;
  lane_elem_t  lidx;
  elem_idx_t   gidx;
  elem_t       op_a;
  elem_t       op_b;
  elem_t       imm_ext;
  elem_t       result;
  logic        wr_en;

  // Local elements whose global index e = l * NR_LANES + LaneId is below vl
  always_comb begin
    if (lane_req_i.vl > vl_t'(LaneId)) begin
      req_cnt = cnt_t'((int'(lane_req_i.vl) - LaneId + `VU_NR_LANES - 1) / `VU_NR_LANES);
    end else begin
      req_cnt = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Element loop
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= LANE_IDLE;
      elem_q  <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (lane_req_valid_i) begin
            state_q <= LANE_RUN;
            elem_q  <= '0;
            cnt_q   <= req_cnt;
          end
        end
        LANE_RUN: begin
          if (elem_q == cnt_q) begin
            state_q <= LANE_IDLE;
          end else begin
            elem_q <= elem_q + 1'b1;
          end
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_req_valid_i && (state_q == LANE_IDLE)) begin
      req_q <= lane_req_i;
    end
  end

  assign wr_en       = (state_q == LANE_RUN) && (elem_q != cnt_q);
  assign lane_done_o = (state_q == LANE_RUN) && (elem_q == cnt_q);

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  assign lidx    = lane_elem_t'(elem_q);
  assign gidx    = elem_idx_t'(int'(lidx) * `VU_NR_LANES + LaneId);
  assign op_a    = vrf_q[req_q.vs2][lidx];
  assign op_b    = vrf_q[req_q.vs1][lidx];
  // Sign extended 5-bit immediate
  assign imm_ext = {{(`VU_ELEM_W - $bits(imm_t)){req_q.imm[$bits(imm_t)-1]}}, req_q.imm};

  always_comb begin
    case (req_q.op)
      OP_ADD:  result = op_a + op_b;
      OP_SUB:  result = op_a - op_b;
      OP_AND:  result = op_a & op_b;
      OP_OR:   result = op_a | op_b;
      OP_XOR:  result = op_a ^ op_b;
      OP_ADDI: result = op_a + imm_ext;
      OP_MVI:  result = imm_ext;
      OP_VID:  result = elem_t'(gidx);
      default: result = '0;
    endcase
  end

  // Register file write and debug read port
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      vrf_q[req_q.vd][lidx] <= result;
    end
    rd_data_o <= vrf_q[rd_vreg_i][rd_lelem_i];
  end

endmodule

//--- logic/vu_top.sv
// Top level joining decoder, instruction FIFO, sequencer, lanes and the debug read mux
`timescale 1ns/1ps
`include "vu_consts.svh"

module vu_top (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              issue_valid_i,
  input  vu_pkg::insn_t     issue_instr_i,
  output logic              issue_ready_o,
  output logic              issue_accept_o,
  output logic              idle_o,
  input  logic              rd_req_i,
  input  vu_pkg::vreg_t     rd_vreg_i,
  input  vu_pkg::elem_idx_t rd_elem_i,
  output vu_pkg::elem_t     rd_data_o,
  output logic              rd_valid_o
);

  import vu_pkg::*;

  localparam int unsigned LaneSelW = $clog2(`VU_NR_LANES);

  vu_insn_t                dec_insn;
  vu_insn_t                head_insn;
  logic                    push;
  logic                    pop;
  logic                    fifo_full;
  logic                    fifo_empty;
  lane_req_t               lane_req;
  logic                    lane_req_valid;
  logic [`VU_NR_LANES-1:0] lane_done;
  logic                    seq_idle;
  elem_t                   lane_rd_data [`VU_NR_LANES];
  lane_elem_t              rd_lelem;
  logic [LaneSelW-1:0]     rd_sel;
  logic [LaneSelW-1:0]     rd_sel_q;
  logic                    rd_valid_q;

  ////////////////////////////////////////////////////////////
  // Issue path
  ////////////////////////////////////////////////////////////

  vu_issue_decoder vu_issue_decoder_i (
    .issue_valid_i  (issue_valid_i ),
    .issue_instr_i  (issue_instr_i ),
    .fifo_full_i    (fifo_full     ),
    .issue_accept_o (issue_accept_o),
    .push_o         (push          ),
    .insn_o         (dec_insn      )
  );

  vu_insn_fifo #(
    .DEPTH (`VU_FIFO_DEPTH),
    .dtype (vu_insn_t     )
  ) vu_insn_fifo_i (
    .clk_i   (clk_i     ),
    .reset_i (reset_i   ),
    .push_i  (push      ),
    .data_i  (dec_insn  ),
    .pop_i   (pop       ),
    .data_o  (head_insn ),
    .full_o  (fifo_full ),
    .empty_o (fifo_empty)
  );

  assign issue_ready_o = !fifo_full;

  vu_sequencer vu_sequencer_i (
    .clk_i            (clk_i         ),
    .reset_i          (reset_i       ),
    .insn_i           (head_insn     ),
    .empty_i          (fifo_empty    ),
    .pop_o            (pop           ),
    .lane_req_o       (lane_req      ),
    .lane_req_valid_o (lane_req_valid),
    .lane_done_i      (lane_done     ),
    .idle_o           (seq_idle      )
  );

  // Nothing queued and nothing in flight
  assign idle_o = fifo_empty && seq_idle;

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  // Element e sits in lane e mod NR_LANES at local index e div NR_LANES
  assign rd_sel   = rd_elem_i[LaneSelW-1:0];
  assign rd_lelem = rd_elem_i[$bits(elem_idx_t)-1:LaneSelW];

  for (genvar l = 0; l < `VU_NR_LANES; l++) begin : gen_lanes
    vu_lane #(
      .LaneId (l)
    ) vu_lane_i (
      .clk_i            (clk_i          ),
      .reset_i          (reset_i        ),
      .lane_req_i       (lane_req       ),
      .lane_req_valid_i (lane_req_valid ),
      .lane_done_o      (lane_done[l]   ),
      .rd_vreg_i        (rd_vreg_i      ),
      .rd_lelem_i       (rd_lelem       ),
      .rd_data_o        (lane_rd_data[l])
    );
  end : gen_lanes

  // Debug read returns one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_sel_q <= rd_sel;
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = lane_rd_data[rd_sel_q];

endmodule

//--- verif/vu_assert.sv
// Concurrent assertions on the vu_top debug read, issue and idle timing, bound to vu_top
`timescale 1ns/1ps

module vu_assert (
  input logic clk_i,
  input logic reset_i,
  input logic issue_valid_i,
  input logic issue_ready_o,
  input logic issue_accept_o,
  input logic idle_o,
  input logic rd_req_i,
  input logic rd_valid_o
);

  // Debug read answers exactly one cycle after the request
  assert property (@(posedge clk_i) disable iff (reset_i) rd_req_i |=> rd_valid_o)
    else $error("rd_valid_o missing one cycle after rd_req_i");

  assert property (@(posedge clk_i) disable iff (reset_i) !rd_req_i |=> !rd_valid_o)
    else $error("rd_valid_o high without a read request");

  // No accept without room in the FIFO
  assert property (@(posedge clk_i) disable iff (reset_i) issue_accept_o |-> issue_ready_o)
    else $error("issue_accept_o high while issue_ready_o low");

  // A taken instruction makes the unit busy
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (issue_valid_i && issue_accept_o) |=> !idle_o)
    else $error("idle_o high right after an accepted issue");

endmodule

bind vu_top vu_assert vu_assert_i (.*);

//--- verif/vu_tb.sv
// Testbench for vu_top with stimulus table, reference model, compare tasks and watchdog
`timescale 1ns/1ps
`include "vu_consts.svh"

module vu_tb;

  import vu_pkg::*;

  localparam int ClkPeriod   = 100;
  localparam int DrvDelay    = 5;
  localparam int ResetCycles = 16;
  localparam int NrTests     = 6;

  typedef struct packed {
    insn_t      insn;
    vu_op_e     op;
    logic       accept;
    logic       burst;
    logic       last;
    logic [2:0] test;
  } row_t;

  logic      clk;
  logic      reset;
  logic      issue_valid;
  insn_t     issue_instr;
  logic      issue_ready;
  logic      issue_accept;
  logic      idle;
  logic      rd_req;
  vreg_t     rd_vreg;
  elem_idx_t rd_elem;
  elem_t     rd_data;
  logic      rd_valid;

  row_t        stim_q [$];
  int          n_rows;
  int          err_cnt;
  int          chk_cnt;
  logic [31:0] lfsr_state;
  logic [`VU_NR_VREGS-1:0] touched;
  elem_t       model_vrf [`VU_NR_VREGS][`VU_VLMAX];
  int          model_vl;
  string       test_name [NrTests];

  vu_top vu_top_i (
    .clk_i          (clk         ),
    .reset_i        (reset       ),
    .issue_valid_i  (issue_valid ),
    .issue_instr_i  (issue_instr ),
    .issue_ready_o  (issue_ready ),
    .issue_accept_o (issue_accept),
    .idle_o         (idle        ),
    .rd_req_i       (rd_req      ),
    .rd_vreg_i      (rd_vreg     ),
    .rd_elem_i      (rd_elem     ),
    .rd_data_o      (rd_data     ),
    .rd_valid_o     (rd_valid    )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'hA300_0000;
    end
    return lfsr_state[0];
  endfunction

  function automatic imm_t rand_imm();
    imm_t v;
    for (int i = 0; i < $bits(imm_t); i++) begin
      v[i] = lfsr_bit();
    end
    return v;
  endfunction

  function automatic insn_t enc_vv(logic [5:0] f6, vreg_t vd, vreg_t vs2, vreg_t vs1);
    return {f6, 1'b1, vs2, vs1, `VU_F3_OPIVV, vd, `VU_OPC_OPV};
  endfunction

  function automatic insn_t enc_vi(logic [5:0] f6, vreg_t vd, vreg_t vs2, imm_t imm);
    return {f6, 1'b1, vs2, imm, `VU_F3_OPIVI, vd, `VU_OPC_OPV};
  endfunction

  function automatic insn_t enc_vid(vreg_t vd);
    return {`VU_F6_VID, 1'b1, 5'd0, `VU_VID_VS1, `VU_F3_OPMVV, vd, `VU_OPC_OPV};
  endfunction

  // vsetivli with an arbitrary vtype field
  function automatic insn_t enc_setvl(imm_t uimm);
    return {2'b11, 10'h0d0, uimm, `VU_F3_OPCFG, 5'd0, `VU_OPC_OPV};
  endfunction

  task automatic add_row(insn_t w, vu_op_e op, logic acc, logic burst, logic last, int test);
    row_t r;
    r.insn   = w;
    r.op     = op;
    r.accept = acc;
    r.burst  = burst;
    r.last   = last;
    r.test   = 3'(test);
    stim_q.push_back(r);
  endtask

  task automatic build_table();
    insn_t w;
    // Full-length fill right after reset
    add_row(enc_vi(`VU_F6_MV, 5'd1, 5'd0, rand_imm()), OP_MVI, 1'b1, 1'b0, 1'b1, 0);
    // Legal words followed by four illegal ones aimed at live registers
    add_row(enc_vid(5'd2), OP_VID, 1'b1, 1'b0, 1'b0, 1);
    add_row(enc_vv(`VU_F6_ADD, 5'd3, 5'd1, 5'd2), OP_ADD, 1'b1, 1'b0, 1'b0, 1);
    w = enc_vv(`VU_F6_ADD, 5'd1, 5'd2, 5'd3);
    w[6:0] = 7'b0100111;
    add_row(w, OP_ADD, 1'b0, 1'b0, 1'b0, 1);
    w = enc_vv(`VU_F6_SUB, 5'd2, 5'd1, 5'd3);
    w[25] = 1'b0;
    add_row(w, OP_SUB, 1'b0, 1'b0, 1'b0, 1);
    add_row(enc_vv(6'b000001, 5'd3, 5'd1, 5'd1), OP_ADD, 1'b0, 1'b0, 1'b0, 1);
    w = enc_vid(5'd1);
    w[19:15] = 5'd0;
    add_row(w, OP_VID, 1'b0, 1'b0, 1'b1, 1);
    // Fills with one forced negative immediate
    add_row(enc_vi(`VU_F6_MV, 5'd4, 5'd0, rand_imm()), OP_MVI, 1'b1, 1'b0, 1'b0, 2);
    add_row(enc_vid(5'd5), OP_VID, 1'b1, 1'b0, 1'b0, 2);
    add_row(enc_vi(`VU_F6_MV, 5'd6, 5'd0, rand_imm() | 5'b10000), OP_MVI,
            1'b1, 1'b0, 1'b1, 2);
    // Element-wise arithmetic and logic
    add_row(enc_vv(`VU_F6_ADD, 5'd7, 5'd4, 5'd5), OP_ADD, 1'b1, 1'b0, 1'b0, 3);
    add_row(enc_vv(`VU_F6_SUB, 5'd8, 5'd5, 5'd4), OP_SUB, 1'b1, 1'b0, 1'b0, 3);
    add_row(enc_vv(`VU_F6_AND, 5'd9, 5'd6, 5'd5), OP_AND, 1'b1, 1'b0, 1'b0, 3);
    add_row(enc_vv(`VU_F6_OR, 5'd10, 5'd4, 5'd5), OP_OR, 1'b1, 1'b0, 1'b0, 3);
    add_row(enc_vv(`VU_F6_XOR, 5'd11, 5'd6, 5'd7), OP_XOR, 1'b1, 1'b0, 1'b0, 3);
    add_row(enc_vi(`VU_F6_ADD, 5'd12, 5'd5, rand_imm()), OP_ADDI, 1'b1, 1'b0, 1'b1, 3);
    // Short, empty and clamped vector lengths
    add_row(enc_setvl(5'd3), OP_SETVL, 1'b1, 1'b0, 1'b0, 4);
    add_row(enc_vv(`VU_F6_ADD, 5'd7, 5'd5, 5'd5), OP_ADD, 1'b1, 1'b0, 1'b0, 4);
    add_row(enc_vi(`VU_F6_MV, 5'd8, 5'd0, rand_imm()), OP_MVI, 1'b1, 1'b0, 1'b0, 4);
    add_row(enc_setvl(5'd0), OP_SETVL, 1'b1, 1'b0, 1'b0, 4);
    add_row(enc_vi(`VU_F6_MV, 5'd9, 5'd0, rand_imm()), OP_MVI, 1'b1, 1'b0, 1'b0, 4);
    add_row(enc_setvl(5'd20), OP_SETVL, 1'b1, 1'b0, 1'b0, 4);
    add_row(enc_vi(`VU_F6_MV, 5'd10, 5'd0, rand_imm()), OP_MVI, 1'b1, 1'b0, 1'b1, 4);
    // Back-to-back issue where the sixth word meets a full FIFO
    add_row(enc_vi(`VU_F6_ADD, 5'd1, 5'd1, rand_imm()), OP_ADDI, 1'b1, 1'b1, 1'b0, 5);
    add_row(enc_vv(`VU_F6_XOR, 5'd2, 5'd1, 5'd4), OP_XOR, 1'b1, 1'b1, 1'b0, 5);
    add_row(enc_vv(`VU_F6_SUB, 5'd3, 5'd2, 5'd5), OP_SUB, 1'b1, 1'b1, 1'b0, 5);
    add_row(enc_vi(`VU_F6_MV, 5'd11, 5'd0, rand_imm()), OP_MVI, 1'b1, 1'b1, 1'b0, 5);
    add_row(enc_vid(5'd12), OP_VID, 1'b1, 1'b1, 1'b0, 5);
    add_row(enc_vi(`VU_F6_ADD, 5'd6, 5'd6, 5'd1), OP_ADDI, 1'b0, 1'b1, 1'b1, 5);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic elem_t sext_imm(imm_t imm);
    return elem_t'($signed(imm));
  endfunction

  task automatic model_apply(row_t r);
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    imm_t  imm;
    vd  = r.insn[11:7];
    vs1 = r.insn[19:15];
    vs2 = r.insn[24:20];
    imm = r.insn[19:15];
    if (r.op == OP_SETVL) begin
      model_vl = (int'(imm) > `VU_VLMAX) ? `VU_VLMAX : int'(imm);
    end else begin
      // Only elements below vl change
      for (int e = 0; e < model_vl; e++) begin
        case (r.op)
          OP_ADD:  model_vrf[vd][e] = model_vrf[vs2][e] + model_vrf[vs1][e];
          OP_SUB:  model_vrf[vd][e] = model_vrf[vs2][e] - model_vrf[vs1][e];
          OP_AND:  model_vrf[vd][e] = model_vrf[vs2][e] & model_vrf[vs1][e];
          OP_OR:   model_vrf[vd][e] = model_vrf[vs2][e] | model_vrf[vs1][e];
          OP_XOR:  model_vrf[vd][e] = model_vrf[vs2][e] ^ model_vrf[vs1][e];
          OP_ADDI: model_vrf[vd][e] = model_vrf[vs2][e] + sext_imm(imm);
          OP_MVI:  model_vrf[vd][e] = sext_imm(imm);
          OP_VID:  model_vrf[vd][e] = elem_t'(e);
          default: ;
        endcase
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks and DUT access
  ////////////////////////////////////////////////////////////

  task automatic check_accept(string name, logic exp, logic got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH time=%0t signal=%s expected=%b got=%b", $time, name, exp, got);
    end
  endtask

  task automatic check_elem(string name, elem_t exp, elem_t got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic report_error(string what);
    err_cnt++;
    $display("ERROR at time %0t: %s", $time, what);
  endtask

  task automatic wait_ready();
    @(negedge clk);
    while (!issue_ready) @(negedge clk);
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!idle) @(negedge clk);
  endtask

  task automatic read_elem(vreg_t v, elem_idx_t e, output elem_t data);
    @(posedge clk);
    #DrvDelay;
    rd_req  = 1'b1;
    rd_vreg = v;
    rd_elem = e;
    @(posedge clk);
    #DrvDelay;
    rd_req = 1'b0;
    @(negedge clk);
    if (rd_valid !== 1'b1) begin
      report_error($sformatf("no read data returned for v%0d element %0d", v, e));
    end
    data = rd_data;
  endtask

  // Every element of each register touched by the group
  task automatic read_touched();
    elem_t got;
    for (int v = 0; v < `VU_NR_VREGS; v++) begin
      if (touched[v]) begin
        for (int e = 0; e < `VU_VLMAX; e++) begin
          read_elem(vreg_t'(v), elem_idx_t'(e), got);
          check_elem($sformatf("rd_data_o v%0d[%0d]", v, e), model_vrf[v][e], got);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    row_t r;
    int   err_base;
    int   chk_base;
    logic has_burst;
    logic ready_dropped;
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue_instr = '0;
    rd_req      = 1'b0;
    rd_vreg     = '0;
    rd_elem     = '0;
    err_cnt     = 0;
    chk_cnt     = 0;
    err_base    = 0;
    chk_base    = 0;
    touched     = '0;
    model_vl    = `VU_VLMAX;
    lfsr_state  = 32'd80512;
    has_burst     = 1'b0;
    ready_dropped = 1'b0;
    test_name = '{"reset", "accept", "fill", "arith", "vsetivli", "burst"};
    build_table();
    n_rows = stim_q.size();

    repeat (ResetCycles) @(posedge clk);
    #DrvDelay;
    reset = 1'b0;
    @(negedge clk);
    check_accept("issue_ready_o", 1'b1, issue_ready);
    check_accept("idle_o", 1'b1, idle);
    check_accept("rd_valid_o", 1'b0, rd_valid);

    for (int i = 0; i < n_rows; i++) begin
      r = stim_q[i];
      if (!r.burst) begin
        wait_ready();
      end
      @(posedge clk);
      #DrvDelay;
      issue_valid = 1'b1;
      issue_instr = r.insn;
      @(negedge clk);
      check_accept("issue_accept_o", r.accept, issue_accept);
      if (r.burst) begin
        has_burst = 1'b1;
        if (!issue_ready) ready_dropped = 1'b1;
      end
      if (r.accept) begin
        model_apply(r);
      end
      if (r.op != OP_SETVL) begin
        touched[r.insn[11:7]] = 1'b1;
      end
      // Keep valid high only between consecutive burst rows
      if (!(r.burst && (i + 1 < n_rows) && stim_q[i + 1].burst)) begin
        @(posedge clk);
        #DrvDelay;
        issue_valid = 1'b0;
      end
      if (r.last) begin
        wait_idle();
        if (has_burst && !ready_dropped) begin
          report_error("issue_ready_o never went low during the burst");
        end
        read_touched();
        $display("test %0d %s : %0d checks, %0d errors", r.test, test_name[r.test],
                 chk_cnt - chk_base, err_cnt - err_base);
        touched       = '0;
        has_burst     = 1'b0;
        ready_dropped = 1'b0;
        err_base      = err_cnt;
        chk_base      = chk_cnt;
      end
    end

    $display("tests: %0d  checks: %0d  errors: %0d", NrTests, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (n_rows > 0);
    repeat (n_rows * 40 + 200) @(posedge clk);
    $display("ERROR: watchdog expired, the run took longer than %0d cycles",
             n_rows * 40 + 200);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+logic
logic/vu_pkg.sv
logic/vu_issue_decoder.sv
logic/vu_insn_fifo.sv
logic/vu_sequencer.sv
logic/vu_lane.sv
logic/vu_top.sv
verif/vu_assert.sv
verif/vu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f src.f --top-module vu_tb -o vu_tb_sim \
  && ./obj_dir/vu_tb_sim 2>&1 | tee sim.log \
  || { echo "Build or simulation error"; exit 1; }

if grep -q "Simulation FAILED" sim.log; then
  echo "Failure reported in sim.log"
  exit 1
fi
echo "Run complete, see sim.log"
exit 0
